//--- src.f
verilog/wb_ic_pkg.sv
verilog/wb_master_port.sv
verilog/wb_rr_arbiter.sv
verilog/wb_xbar_route.sv
verilog/wb_decode_err_target.sv
verilog/wb_interconnect_4x2.sv
tb/wb_target_model.sv
tb/tb_wb_interconnect.sv

//--- tb/wb_stim.txt
# group master op address wdata exp_rdata exp_err (hex data, bits 31:28 of wdata = master)
# Groups 0 to 2 check round-robin order, 3 read-back, 4 unmapped, 5 mixed, 6 and 7 slow target
0 0 W 00000010 00001111 00000000 0
0 1 W 00000014 10002222 00000000 0
0 2 W 00000018 20003333 00000000 0
0 3 W 0000001c 30004444 00000000 0
1 1 W 00000020 10005555 00000000 0
2 0 W 00000030 00006666 00000000 0
2 1 W 00000034 10007777 00000000 0
2 2 W 00000038 20008888 00000000 0
2 3 W 0000003c 30009999 00000000 0
3 0 W 00000100 0eadbeef 00000000 0
3 0 R 00000100 00000000 0eadbeef 0
3 1 W 00001100 1afef00d 00000000 0
3 1 R 00001100 00000000 1afef00d 0
4 0 R 00002000 00000000 00000000 1
4 2 R 00004000 00000000 00000000 1
4 3 W fffffff0 3eeeeeee 00000000 1
5 0 W 00000200 0a0a0a0a 00000000 0
5 0 R 00000200 00000000 0a0a0a0a 0
5 1 W 00000204 1b1b1b1b 00000000 0
5 1 R 00000204 00000000 1b1b1b1b 0
5 2 W 00001200 2c2c2c2c 00000000 0
5 2 R 00001200 00000000 2c2c2c2c 0
5 3 W 00001204 3d3d3d3d 00000000 0
5 3 R 80000000 00000000 00000000 1
6 0 W 00000300 01110000 00000000 0
6 0 W 00000300 01112222 00000000 0
6 0 R 00000300 00000000 01112222 0
6 1 W 00001300 11113333 00000000 0
6 1 R 00001300 00000000 11113333 0
6 2 W 00000304 21114444 00000000 0
6 2 R 00000304 00000000 21114444 0
6 3 W 00001304 31115555 00000000 0
6 3 R 00001304 00000000 31115555 0
7 0 R 00000100 00000000 0eadbeef 0
7 1 R 00001100 00000000 1afef00d 0
7 2 R 00000300 00000000 01112222 0
7 3 R 00001304 00000000 31115555 0

//--- tb/tb_wb_interconnect.sv
/*
 * Testbench for the Wishbone 4x2 interconnect
 * Plays grouped transactions from a stimulus file on four masters and
 * checks responses, routing and round-robin grant order
 */

`timescale 1ns/100ps

module tb_wb_interconnect import wb_ic_pkg::*; ();

	localparam STIM_FILE         = "tb/wb_stim.txt";
	localparam int SEED          = 88;
	localparam int MAX_LINES     = 64;
	localparam int FAST_LAT      = 1;
	localparam int SLOW_LAT      = 6;
	localparam int SLOW_GROUP    = 6;
	localparam int XFER_BOUND_NS = 800;

	logic       clk;
	logic       rstn;
	logic [3:0] lat;
	wb_m2s_t    m_req [N_MASTERS];
	wb_s2m_t    m_rsp [N_MASTERS];
	wb_m2s_t    s_req [N_TARGETS];
	wb_s2m_t    s_rsp [N_TARGETS];

	int          n_lines;
	int          n_groups;
	int          n_done;
	int          errors;
	int          line_grp  [MAX_LINES];
	int          line_mst  [MAX_LINES];
	logic        line_wr   [MAX_LINES];
	logic [31:0] line_adr  [MAX_LINES];
	logic [31:0] line_wdat [MAX_LINES];
	logic [31:0] line_rdat [MAX_LINES];
	logic        line_err  [MAX_LINES];

	wb_interconnect_4x2 wb_interconnect_4x2_inst (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp)
	);

	wb_target_model tgt0_model (
		.clk   (clk),
		.rstn  (rstn),
		.lat_i (lat),
		.req_i (s_req[0]),
		.rsp_o (s_rsp[0])
	);

	wb_target_model tgt1_model (
		.clk   (clk),
		.rstn  (rstn),
		.lat_i (lat),
		.req_i (s_req[1]),
		.rsp_o (s_rsp[1])
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic load_stimulus();
		int            fd;
		int            n;
		int            g;
		int            m;
		int            e;
		logic [7:0]    op;
		logic [31:0]   a;
		logic [31:0]   wd;
		logic [31:0]   rd;
		logic [1023:0] text;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Stimulus file %s could not be opened", STIM_FILE);
			errors++;
			return;
		end
		while (!$feof(fd) && n_lines < MAX_LINES) begin
			text = '0;
			void'($fgets(text, fd));
			// Comment and blank lines never match all seven fields
			n = $sscanf(text, "%d %d %s %h %h %h %d", g, m, op, a, wd, rd, e);
			if (n == 7) begin
				line_grp[n_lines]  = g;
				line_mst[n_lines]  = m;
				line_wr[n_lines]   = (op == "W");
				line_adr[n_lines]  = a;
				line_wdat[n_lines] = wd;
				line_rdat[n_lines] = rd;
				line_err[n_lines]  = e[0];
				if (g >= n_groups) begin
					n_groups = g + 1;
				end
				n_lines++;
			end
		end
		$fclose(fd);
	endtask

	task automatic do_transfer(input int m, input int i);
		wb_m2s_t req;
		wb_s2m_t rsp;
		req       = '0;
		req.adr   = line_adr[i];
		req.dat_w = line_wdat[i];
		req.sel   = 4'hF;
		req.we    = line_wr[i];
		req.cyc   = 1'b1;
		req.stb   = 1'b1;
		@(posedge clk);
		m_req[m] <= req;
		// Responses come from registers, so they are settled at the falling edge
		do begin
			@(negedge clk);
			rsp = m_rsp[m];
		end while (!(rsp.ack || rsp.err));
		@(posedge clk);
		m_req[m] <= '0;
		check_value(rsp.err, line_err[i], $sformatf("err on line %0d, master %0d", i, m));
		check_value(rsp.ack, !line_err[i], $sformatf("ack on line %0d, master %0d", i, m));
		if (!line_wr[i] || line_err[i]) begin
			check_value(rsp.dat_r, line_rdat[i], $sformatf("read data on line %0d", i));
		end
		n_done++;
	endtask

	task automatic run_master_group(input int m, input int g);
		logic first;
		first = 1'b1;
		for (int i = 0; i < n_lines; i++) begin
			if (line_grp[i] == g && line_mst[i] == m) begin
				// Idle gap only between a master's own transactions
				if (!first) begin
					repeat ($urandom % 4) @(posedge clk);
				end
				first = 1'b0;
				do_transfer(m, i);
			end
		end
	endtask

	// Group of one write per master, all to target 0
	function automatic logic order_group(input int g);
		int         cnt;
		logic [3:0] seen;
		cnt  = 0;
		seen = '0;
		for (int i = 0; i < n_lines; i++) begin
			if (line_grp[i] == g) begin
				cnt++;
				if (line_wr[i] && line_adr[i][31:12] == 0) begin
					seen[line_mst[i]] = 1'b1;
				end
			end
		end
		return cnt == N_MASTERS && seen == 4'hF;
	endfunction

	// Round robin resumes above the last master of an earlier group on target 0,
	// or at master 0 after reset
	task automatic check_grant_order(input int g, input int base);
		int start;
		start = 0;
		for (int i = 0; i < n_lines; i++) begin
			if (line_grp[i] < g && line_adr[i][31:12] == 0) begin
				start = (line_mst[i] + 1) % N_MASTERS;
			end
		end
		check_value(tgt0_model.log_cnt, base + N_MASTERS, $sformatf("writes in group %0d", g));
		for (int k = 0; k < N_MASTERS; k++) begin
			check_value(tgt0_model.log_tag[base+k], (start + k) % N_MASTERS,
				$sformatf("grant slot %0d of group %0d", k, g));
		end
	endtask

	always @(negedge clk) begin
		if (rstn) begin
			// Target t only sees addresses of window t
			for (int t = 0; t < N_TARGETS; t++) begin
				if (s_req[t].stb) begin
					check_value(s_req[t].adr[31:12], t, $sformatf("strobe at target %0d", t));
				end
			end
			for (int m = 0; m < N_MASTERS; m++) begin
				if (!m_req[m].stb) begin
					check_value(m_rsp[m].ack | m_rsp[m].err, 0,
						$sformatf("response to idle master %0d", m));
				end
			end
		end
	end

	initial begin
		wait (n_lines > 0);
		#(n_lines * XFER_BOUND_NS + 200);
		$display("Timeout: the stimulus did not finish within %0d ns", n_lines * XFER_BOUND_NS);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic order;
		int   base;
		rstn     = 1'b0;
		lat      = FAST_LAT;
		errors   = 0;
		n_done   = 0;
		n_lines  = 0;
		n_groups = 0;
		for (int m = 0; m < N_MASTERS; m++) begin
			m_req[m] = '0;
		end
		void'($urandom(SEED));
		load_stimulus();
		@(posedge clk);
		@(negedge clk);
		check_value(s_req[0].cyc | s_req[0].stb | s_req[1].cyc | s_req[1].stb, 0, "reset strobe");
		@(posedge clk);
		rstn <= 1'b1;
		for (int g = 0; g < n_groups; g++) begin
			order = order_group(g);
			base  = tgt0_model.log_cnt;
			@(posedge clk);
			lat <= (g >= SLOW_GROUP) ? SLOW_LAT : FAST_LAT;
			fork
				run_master_group(0, g);
				run_master_group(1, g);
				run_master_group(2, g);
				run_master_group(3, g);
			join
			if (order) begin
				check_grant_order(g, base);
			end
		end
		repeat (4) @(posedge clk);
		check_value(n_done, n_lines, "completed transactions");
		$display("Run done: %0d of %0d transactions, %0d errors", n_done, n_lines, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- tb/wb_target_model.sv
/*
 * Behavioral Wishbone memory target
 * Answers each strobe after a programmable number of wait cycles
 * and logs the master tag of every write
 */

`timescale 1ns/100ps

module wb_target_model import wb_ic_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic [3:0] lat_i,
	input  wb_m2s_t    req_i,
	output wb_s2m_t    rsp_o
);

	localparam int LOG_DEPTH = 64;

	logic [WB_DATA_W-1:0] mem [0:1023];
	logic [3:0]           log_tag [0:LOG_DEPTH-1];
	int                   log_cnt;
	logic [3:0]           wait_cnt;
	logic                 busy;
	logic [9:0]           idx;

	// Word index inside the 4 KB window
	assign idx = req_i.adr[11:2];

	always @(posedge clk) begin
		if (!rstn) begin
			rsp_o    <= '0;
			wait_cnt <= '0;
			busy     <= 1'b0;
			log_cnt  <= 0;
		end else begin
			rsp_o.ack <= 1'b0;
			if (req_i.cyc && req_i.stb && !busy) begin
				if (wait_cnt == lat_i) begin
					rsp_o.ack   <= 1'b1;
					rsp_o.dat_r <= req_i.we ? '0 : mem[idx];
					busy        <= 1'b1;
					wait_cnt    <= '0;
					if (req_i.we) begin
						mem[idx] <= req_i.dat_w;
						// Upper nibble of write data names the master
						if (log_cnt < LOG_DEPTH) begin
							log_tag[log_cnt] <= req_i.dat_w[31:28];
							log_cnt          <= log_cnt + 1;
						end
					end
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end else if (!req_i.stb) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

//--- verilog/wb_interconnect_4x2.sv
/*
 * Wishbone classic interconnect, four masters to two targets
 * Per-master decode, per-target round-robin arbitration and an
 * internal error target for unmapped addresses
 */

`timescale 1ns/100ps

module wb_interconnect_4x2 import wb_ic_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  wb_m2s_t m_req_i [N_MASTERS],
	output wb_s2m_t m_rsp_o [N_MASTERS],
	output wb_m2s_t s_req_o [N_TARGETS],
	input  wb_s2m_t s_rsp_i [N_TARGETS]
);

	target_e              m_sel   [N_MASTERS];
	logic [N_MASTERS-1:0] arb_req [N_ARB];
	logic                 gnt     [N_ARB];
	logic [MID_W-1:0]     gnt_id  [N_ARB];
	wb_m2s_t              t_req   [N_ARB];
	wb_s2m_t              t_rsp   [N_ARB];

	// Decode stage, one port per master
	for (genvar m = 0; m < N_MASTERS; m++) begin : g_port
		wb_master_port port_inst (
			.clk       (clk),
			.rstn      (rstn),
			.req_i     (m_req_i[m]),
			.rsp_i     (m_rsp_o[m]),
			.sel_tgt_o (m_sel[m])
		);
	end

	// One arbiter per target, the last one guards the error target
	for (genvar t = 0; t < N_ARB; t++) begin : g_arb
		wb_rr_arbiter #(
			.N_REQ (N_MASTERS)
		) arb_inst (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (arb_req[t]),
			.gnt_o    (gnt[t]),
			.gnt_id_o (gnt_id[t])
		);
	end

	wb_xbar_route route_inst (
		.m_req_i   (m_req_i),
		.m_sel_i   (m_sel),
		.gnt_i     (gnt),
		.gnt_id_i  (gnt_id),
		.t_rsp_i   (t_rsp),
		.arb_req_o (arb_req),
		.t_req_o   (t_req),
		.m_rsp_o   (m_rsp_o)
	);

	// External targets sit on router outputs 0 and 1
	for (genvar t = 0; t < N_TARGETS; t++) begin : g_ext
		assign s_req_o[t] = t_req[t];
		assign t_rsp[t]   = s_rsp_i[t];
	end

	wb_decode_err_target err_inst (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (t_req[N_TARGETS]),
		.rsp_o (t_rsp[N_TARGETS])
	);

endmodule

//--- verilog/wb_decode_err_target.sv
/*
 * Decode-error target
 * Answers every strobe to an unmapped address with a one-cycle err
 */

`timescale 1ns/100ps

module wb_decode_err_target import wb_ic_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  wb_m2s_t req_i,
	output wb_s2m_t rsp_o
);

	logic err_q;
	logic busy_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q  <= 1'b0;
			busy_q <= 1'b0;
		end else begin
			err_q <= 1'b0;
			if (req_i.cyc && req_i.stb && !busy_q) begin
				err_q  <= 1'b1;
				busy_q <= 1'b1;
			end else if (!req_i.stb) begin
				busy_q <= 1'b0;  // rearm once the strobe is gone
			end
		end
	end

	assign rsp_o.dat_r = '0;
	assign rsp_o.ack   = 1'b0;
	assign rsp_o.err   = err_q;

	// The err pulse lands while the strobe that caused it is still held
	a_err_in_cycle: assert property (
		@(posedge clk) disable iff (!rstn)
		rsp_o.err |-> req_i.cyc && req_i.stb
	);

endmodule

//--- verilog/wb_xbar_route.sv
/*
 * Wishbone crossbar routing fabric
 * Builds per-target request vectors, forwards the granted request
 * and returns each response to the granted master only
 */

`timescale 1ns/100ps

module wb_xbar_route import wb_ic_pkg::*; (
	input  wb_m2s_t              m_req_i   [N_MASTERS],
	input  target_e              m_sel_i   [N_MASTERS],
	input  logic                 gnt_i     [N_ARB],
	input  logic [MID_W-1:0]     gnt_id_i  [N_ARB],
	input  wb_s2m_t              t_rsp_i   [N_ARB],
	output logic [N_MASTERS-1:0] arb_req_o [N_ARB],
	output wb_m2s_t              t_req_o   [N_ARB],
	output wb_s2m_t              m_rsp_o   [N_MASTERS]
);

	// Request vector per target, bit m set when master m decoded to it
	always_comb begin
		for (int t = 0; t < N_ARB; t++) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				arb_req_o[t][m] = (m_sel_i[m] == target_e'(t));
			end
		end
	end

	// Forward the granted master, idle bus when nobody holds the target
	always_comb begin
		for (int t = 0; t < N_ARB; t++) begin
			if (gnt_i[t]) begin
				t_req_o[t] = m_req_i[gnt_id_i[t]];
			end else begin
				t_req_o[t] = '0;
			end
		end
	end

	// Response steering
	// ack and err pass through without a register stage
	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			m_rsp_o[m] = '0;
			for (int t = 0; t < N_ARB; t++) begin
				if (gnt_i[t] && gnt_id_i[t] == MID_W'(m)) begin
					m_rsp_o[m] = t_rsp_i[t];
				end
			end
		end
	end

endmodule

//--- verilog/wb_rr_arbiter.sv
/*
 * Round-robin arbiter for one target
 * Picks the lowest request above the last grant and holds the
 * grant until the granted request bit clears
 */

`timescale 1ns/100ps

module wb_rr_arbiter import wb_ic_pkg::*; #(
	parameter int N_REQ = 4
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [N_REQ-1:0]         req_i,
	output logic                     gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);

	arb_state_e       state_q;
	logic [N_REQ-1:0] gnt_vec;
	logic [N_REQ-1:0] last_gnt;
	logic [N_REQ-1:0] above_last;
	logic [N_REQ-1:0] masked_req;
	logic [N_REQ-1:0] pick;

	// Isolate the lowest set bit
	function automatic logic [N_REQ-1:0] lowest_set(input logic [N_REQ-1:0] vec);
		return vec & (~vec + 1'b1);
	endfunction

	function automatic logic [$clog2(N_REQ)-1:0] onehot_to_id(input logic [N_REQ-1:0] vec);
		logic [$clog2(N_REQ)-1:0] id;
		id = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (vec[i]) begin
				id = id | ($clog2(N_REQ))'(i);
			end
		end
		return id;
	endfunction

	// Mask of positions strictly above the last grant, empty after reset
	always_comb begin
		above_last = '0;
		for (int i = 1; i < N_REQ; i++) begin
			above_last[i] = above_last[i-1] | last_gnt[i-1];
		end
	end

	assign masked_req = req_i & above_last;
	assign pick       = (|masked_req) ? lowest_set(masked_req) : lowest_set(req_i);
	assign gnt_o      = |gnt_vec;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q  <= ARB_IDLE;
			gnt_vec  <= '0;
			last_gnt <= '0;
			gnt_id_o <= '0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (|req_i) begin
						state_q  <= ARB_HELD;
						gnt_vec  <= pick;
						last_gnt <= pick;
						gnt_id_o <= onehot_to_id(pick);
					end
				end

				ARB_HELD: begin
					if (!(|(gnt_vec & req_i))) begin
						state_q <= ARB_IDLE;
						gnt_vec <= '0;
					end
				end

				default: state_q <= ARB_IDLE;
			endcase
		end
	end

	a_gnt_onehot: assert property (
		@(posedge clk) disable iff (!rstn)
		$onehot0(gnt_vec)
	);

endmodule

//--- verilog/wb_master_port.sv
/*
 * Wishbone master port
 * Tracks one classic cycle per master and decodes its address
 * into target 0, target 1 or the decode-error target
 */

`timescale 1ns/100ps

module wb_master_port import wb_ic_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  wb_m2s_t req_i,
	input  wb_s2m_t rsp_i,
	output target_e sel_tgt_o
);

	port_state_e state_q;
	target_e     decode_tgt;
	logic        new_cycle;
	logic        cycle_done;

	// Address window lookup, anything unmapped goes to the error target
	function automatic target_e decode_addr(input logic [WB_ADDR_W-1:0] adr);
		target_e tgt;
		tgt = TGT_ERR;
		if (adr >= TGT0_BASE && adr <= TGT0_LIMIT) begin
			tgt = TGT_S0;
		end else if (adr >= TGT1_BASE && adr <= TGT1_LIMIT) begin
			tgt = TGT_S1;
		end
		return tgt;
	endfunction

	assign new_cycle  = req_i.cyc & req_i.stb;
	assign cycle_done = rsp_i.ack | rsp_i.err;
	assign decode_tgt = decode_addr(req_i.adr);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q   <= PORT_IDLE;
			sel_tgt_o <= TGT_NONE;
		end else begin
			case (state_q)
				PORT_IDLE: begin
					// Address is stable with stb, so decode it once
					if (new_cycle) begin
						state_q   <= PORT_WAIT;
						sel_tgt_o <= decode_tgt;
					end
				end

				PORT_WAIT: begin
					// Drop the request as soon as the target answers
					if (cycle_done) begin
						state_q   <= PORT_IDLE;
						sel_tgt_o <= TGT_NONE;
					end
				end

				default: begin
					state_q   <= PORT_IDLE;
					sel_tgt_o <= TGT_NONE;
				end
			endcase
		end
	end

	// A response may only come back for a cycle this port has routed
	a_rsp_only_when_waiting: assert property (
		@(posedge clk) disable iff (!rstn)
		cycle_done |-> state_q == PORT_WAIT
	);

	// Router must never pass ack and err together
	a_rsp_exclusive: assert property (
		@(posedge clk) disable iff (!rstn)
		!(rsp_i.ack && rsp_i.err)
	);

endmodule

//--- verilog/wb_ic_pkg.sv
/*
 * Wishbone 4x2 interconnect shared definitions
 * Address map, port counts, bus structs and state encodings
 */

package wb_ic_pkg;

	// Bus widths
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = WB_DATA_W / 8;

	// Port counts
	localparam int N_MASTERS = 4;
	localparam int N_TARGETS = 2;
	localparam int MID_W     = 2;

	// One arbiter per real target plus the decode-error target
	localparam int N_ARB = N_TARGETS + 1;

	// Address map, limits are inclusive
	localparam logic [WB_ADDR_W-1:0] TGT0_BASE  = 32'h0000_0000;
	localparam logic [WB_ADDR_W-1:0] TGT0_LIMIT = 32'h0000_0FFF;
	localparam logic [WB_ADDR_W-1:0] TGT1_BASE  = 32'h0000_1000;
	localparam logic [WB_ADDR_W-1:0] TGT1_LIMIT = 32'h0000_1FFF;

	// Request driven by a master, 71 bits
	typedef struct packed {
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat_w;
		logic [WB_SEL_W-1:0]  sel;
		logic                 we;
		logic                 cyc;
		logic                 stb;
	} wb_m2s_t;

	// Response driven by a target, 34 bits
	typedef struct packed {
		logic [WB_DATA_W-1:0] dat_r;
		logic                 ack;
		logic                 err;
	} wb_s2m_t;

	// Decode result, values 0..2 double as arbiter index
	typedef enum logic [1:0] {
		TGT_S0   = 2'd0,
		TGT_S1   = 2'd1,
		TGT_ERR  = 2'd2,
		TGT_NONE = 2'd3
	} target_e;

	typedef enum logic {PORT_IDLE, PORT_WAIT} port_state_e;

	typedef enum logic {ARB_IDLE, ARB_HELD} arb_state_e;

endpackage
